//--- filelist.f
hdl/vwrite_pkg.sv
hdl/addr_gen.sv
hdl/mem_reader.sv
hdl/dp_buffer.sv
hdl/write_ctrl.sv
hdl/vwrite_unit.sv
bench/vwrite_sva.sv
bench/vwrite_tb.sv

//--- run.sh
#!/bin/sh
# build the simulation with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module vwrite_tb -f filelist.f -o vwrite_sim \
   && ./obj_dir/vwrite_sim | tee sim.log \
   || echo "build or simulation did not complete"
grep -qx "all tests passed" sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }

//--- bench/vwrite_tb.sv
`timescale 1ns/100ps

module vwrite_tb;
   import vwrite_pkg::*;

   localparam int RST_CYCLES = 10;

   logic      clk;
   logic      rst;
   logic      run_i;
   vw_cfg_t   cfg_i;
   data_t     in_i;
   logic      bus_ready_i;
   logic      bus_last_i;
   logic      done_o;
   logic      bus_valid_o;
   bus_addr_t bus_addr_o;
   data_t     bus_wdata_o;
   len_t      bus_len_o;

   vw_cfg_t run_cfg [$];
   string   run_name [$];
   int      run_ready [$];

   // buffer model filled from the store address and delay rules
   data_t   model_mem [2**ADDR_W];
   logic    pp_model;
   addr_t   rd_start;
   vw_cfg_t cur_cfg;
   string   cur_name;
   int      ready_pct;
   data_t   next_base;
   data_t   base_q;
   data_t   since_run;
   int      beat_cnt;
   int      errors;
   int      tests_passed;
   int      tests_failed;

   vwrite_unit #(
      .FIFO_DEPTH(2)
   ) i_vwrite_unit (
      .clk        (clk),
      .rst        (rst),
      .run_i      (run_i),
      .cfg_i      (cfg_i),
      .in_i       (in_i),
      .bus_ready_i(bus_ready_i),
      .bus_last_i (bus_last_i),
      .done_o     (done_o),
      .bus_valid_o(bus_valid_o),
      .bus_addr_o (bus_addr_o),
      .bus_wdata_o(bus_wdata_o),
      .bus_len_o  (bus_len_o)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   function automatic vw_cfg_t make_cfg(input bus_addr_t ext, input addr_t s_start,
                                        input addr_t s_incr, input period_t s_period,
                                        input delay_t s_delay, input addr_t r_incr,
                                        input len_t len, input logic pp, input logic ew);
      vw_cfg_t c;
      c.ext_addr     = ext;
      c.store_start  = s_start;
      c.store_incr   = s_incr;
      c.store_period = s_period;
      c.store_delay  = s_delay;
      c.read_incr    = r_incr;
      c.read_period  = period_t'(len);
      c.length       = len;
      c.ping_pong    = pp;
      c.enable_write = ew;
      return c;
   endfunction

   // word the k-th beat of the current burst must carry
   function automatic data_t expected_beat(input int k);
      addr_t a;
      a = rd_start + addr_t'(k) * cur_cfg.read_incr;
      return model_mem[a];
   endfunction

   task automatic add_run(input string name, input int ready, input vw_cfg_t c);
      run_name.push_back(name);
      run_ready.push_back(ready);
      run_cfg.push_back(c);
   endtask

   // item k is written delay+1+k cycles after the run pulse
   task automatic record_store(input vw_cfg_t c, input data_t base);
      addr_t a;
      a = {c.ping_pong && pp_model, c.store_start[ADDR_W-2:0]};
      for (int k = 0; k < int'(c.store_period); k++) begin
         model_mem[a] = base + data_t'(c.store_delay) + data_t'(k + 1);
         a = a + c.store_incr;
      end
   endtask

   task automatic close_test(input int start_err);
      if (errors == start_err) begin
         tests_passed++;
         $display("test %s: ok", cur_name);
      end else begin
         tests_failed++;
         $display("test %s: %0d errors", cur_name, errors - start_err);
      end
   endtask

   task automatic check_reset_state();
      int start_err;
      start_err = errors;
      cur_name = "reset_state";
      repeat (5) begin
         assert (done_o && !bus_valid_o)
         else begin
            $display("Fail %s done_o/bus_valid_o: expected 1/0, actual %b/%b",
                     cur_name, done_o, bus_valid_o);
            errors++;
         end
         @(negedge clk);
      end
      close_test(start_err);
   endtask

   task automatic do_run(input int idx);
      vw_cfg_t c;
      int      start_err;
      int      exp_beats;
      c = run_cfg[idx];
      start_err = errors;
      exp_beats = c.enable_write ? int'(c.length) : 0;
      cur_cfg = c;
      cur_name = run_name[idx];
      ready_pct = run_ready[idx];
      next_base = $urandom;
      rd_start = {c.ping_pong && !pp_model, {(ADDR_W-1){1'b0}}};
      record_store(c, next_base);
      pp_model = c.ping_pong && !pp_model;
      cfg_i = c;
      run_i = 1'b1;
      @(negedge clk);
      run_i = 1'b0;
      while (!done_o) @(negedge clk);
      assert (beat_cnt == exp_beats)
      else begin
         $display("Fail %s beat count: expected %0d, actual %0d", cur_name, exp_beats, beat_cnt);
         errors++;
      end
      if (c.enable_write) begin
         assert (bus_addr_o == c.ext_addr)
         else begin
            $display("Fail %s bus_addr: expected %h, actual %h", cur_name, c.ext_addr, bus_addr_o);
            errors++;
         end
         assert (bus_len_o == c.length)
         else begin
            $display("Fail %s bus_len: expected %0d, actual %0d", cur_name, c.length, bus_len_o);
            errors++;
         end
      end
      close_test(start_err);
   endtask

   always @(posedge clk) begin
      if (run_i) begin
         since_run <= data_t'(1);
         base_q    <= next_base;
      end else begin
         since_run <= since_run + data_t'(1);
      end
   end

   // stream data and bus slave
   always @(negedge clk) begin
      if (!rst) begin
         in_i        <= base_q + since_run;
         bus_ready_i <= ($urandom % 100) < ready_pct;
         bus_last_i  <= (beat_cnt == int'(cur_cfg.length) - 1);
      end
   end

   // every accepted beat against the model
   always @(posedge clk) begin
      if (run_i) begin
         beat_cnt <= 0;
      end else if (bus_valid_o && bus_ready_i) begin
         assert (bus_wdata_o == expected_beat(beat_cnt))
         else begin
            $display("Fail %s beat %0d: expected %h, actual %h", cur_name, beat_cnt,
                     expected_beat(beat_cnt), bus_wdata_o);
            errors++;
         end
         beat_cnt <= beat_cnt + 1;
      end
   end

   initial begin
      int limit;
      @(negedge rst);
      limit = 20;
      foreach (run_cfg[i]) begin
         limit += int'(run_cfg[i].store_delay) + int'(run_cfg[i].store_period)
                + int'(run_cfg[i].read_period) + 4 * int'(run_cfg[i].length) + 50;
      end
      repeat (limit) @(posedge clk);
      $display("timeout after %0d cycles, the tests did not finish", limit);
      $display("tests failed");
      $finish;
   end

   initial begin
      void'($urandom(32'h0cee08d4));
      rst = 1'b1;
      run_i = 1'b0;
      cfg_i = '0;
      in_i = '0;
      bus_ready_i = 1'b0;
      bus_last_i = 1'b0;
      cur_cfg = '0;
      pp_model = 1'b0;
      rd_start = '0;
      ready_pct = 100;
      next_base = '0;
      base_q = '0;
      since_run = '0;
      beat_cnt = 0;
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      add_run("delay_store", 100,
              make_cfg(32'h0, 8'h00, 8'd2, 8'd8, 6'd13, 8'd1, 8'd0, 1'b0, 1'b0));
      add_run("delay_read", 100,
              make_cfg(32'h1000_0040, 8'h00, 8'd1, 8'd0, 6'd0, 8'd2, 8'd8, 1'b0, 1'b1));
      add_run("stride_store", 100,
              make_cfg(32'h0, 8'h00, 8'd1, 8'd16, 6'd0, 8'd1, 8'd0, 1'b0, 1'b0));
      add_run("stride_read", 70,
              make_cfg(32'h2000_0100, 8'h00, 8'd1, 8'd0, 6'd0, 8'd3, 8'd6, 1'b0, 1'b1));
      // top bit of store_start is replaced by the half select
      add_run("pp_fill", 100,
              make_cfg(32'h0, 8'h80, 8'd1, 8'd10, 6'd2, 8'd1, 8'd0, 1'b1, 1'b0));
      add_run("pp_swap_a", 60,
              make_cfg(32'h3000_0000, 8'h00, 8'd1, 8'd12, 6'd3, 8'd1, 8'd10, 1'b1, 1'b1));
      add_run("pp_swap_b", 100,
              make_cfg(32'h3000_0400, 8'h00, 8'd1, 8'd6, 6'd1, 8'd1, 8'd12, 1'b1, 1'b1));
      add_run("backpressure", 25,
              make_cfg(32'h4000_0000, 8'h00, 8'd1, 8'd0, 6'd0, 8'd1, 8'd6, 1'b1, 1'b1));
      repeat (RST_CYCLES) @(negedge clk);
      rst = 1'b0;
      check_reset_state();
      for (int i = 0; i < run_cfg.size(); i++) begin
         do_run(i);
      end
      $display("summary: %0d of %0d tests clean, %0d errors", tests_passed,
               tests_passed + tests_failed, errors);
      if (tests_failed == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

//--- bench/vwrite_sva.sv
`timescale 1ns/100ps

module vwrite_sva (
   input logic              clk,
   input logic              rst,
   input logic              done_i,
   input logic              bus_valid_i,
   input logic              bus_ready_i,
   input vwrite_pkg::data_t bus_wdata_i
);

   // a stalled beat keeps valid and data
   a_valid_hold: assert property (@(posedge clk) disable iff (rst)
      bus_valid_i && !bus_ready_i |=> bus_valid_i && $stable(bus_wdata_i))
      else $error("bus valid dropped or write data changed during a stall");

   a_reset_state: assert property (@(posedge clk)
      $fell(rst) |-> done_i && !bus_valid_i)
      else $error("done low or bus valid high when reset is released");

   // no beat outside a run
   a_idle_quiet: assert property (@(posedge clk) disable iff (rst)
      done_i |-> !bus_valid_i)
      else $error("bus valid high while done is high");

endmodule

bind vwrite_unit vwrite_sva i_vwrite_sva (
   .clk        (clk),
   .rst        (rst),
   .done_i     (done_o),
   .bus_valid_i(bus_valid_o),
   .bus_ready_i(bus_ready_i),
   .bus_wdata_i(bus_wdata_o)
);

//--- hdl/vwrite_unit.sv
`timescale 1ns/100ps

module vwrite_unit #(
   parameter int FIFO_DEPTH = 2
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  vwrite_pkg::vw_cfg_t   cfg_i,
   input  vwrite_pkg::data_t     in_i,
   input  logic                  bus_ready_i,
   input  logic                  bus_last_i,
   output logic                  done_o,
   output logic                  bus_valid_o,
   output vwrite_pkg::bus_addr_t bus_addr_o,
   output vwrite_pkg::data_t     bus_wdata_o,
   output vwrite_pkg::len_t      bus_len_o
);
   import vwrite_pkg::*;

   addr_t store_start;
   addr_t read_start;
   logic  read_run;

   // store side
   logic  store_valid;
   addr_t store_addr;
   logic  store_done;

   // read side
   logic  gen_valid;
   logic  gen_ready;
   addr_t gen_addr;
   logic  rd_valid;
   logic  mem_en;
   addr_t mem_addr;
   data_t mem_data;

   write_ctrl i_write_ctrl (
      .clk          (clk),
      .rst          (rst),
      .run_i        (run_i),
      .cfg_i        (cfg_i),
      .store_done_i (store_done),
      .rd_valid_i   (rd_valid),
      .bus_ready_i  (bus_ready_i),
      .bus_last_i   (bus_last_i),
      .done_o       (done_o),
      .bus_valid_o  (bus_valid_o),
      .store_start_o(store_start),
      .read_start_o (read_start),
      .read_run_o   (read_run),
      .bus_addr_o   (bus_addr_o),
      .bus_len_o    (bus_len_o)
   );

   // store generator never stalls, its valid is the write enable
   addr_gen i_store_gen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (run_i),
      .start_i (store_start),
      .incr_i  (cfg_i.store_incr),
      .period_i(cfg_i.store_period),
      .delay_i (cfg_i.store_delay),
      .ready_i (1'b1),
      .valid_o (store_valid),
      .addr_o  (store_addr),
      .done_o  (store_done)
   );

   addr_gen i_read_gen (
      .clk     (clk),
      .rst     (rst),
      .run_i   (read_run),
      .start_i (read_start),
      .incr_i  (cfg_i.read_incr),
      .period_i(cfg_i.read_period),
      .delay_i (delay_t'(0)),
      .ready_i (gen_ready),
      .valid_o (gen_valid),
      .addr_o  (gen_addr),
      .done_o  ()
   );

   mem_reader #(
      .FIFO_DEPTH(FIFO_DEPTH)
   ) i_mem_reader (
      .clk       (clk),
      .rst       (rst),
      .s_valid_i (gen_valid),
      .s_addr_i  (gen_addr),
      .s_ready_o (gen_ready),
      .m_valid_o (rd_valid),
      .m_ready_i (bus_ready_i),
      .m_data_o  (bus_wdata_o),
      .mem_en_o  (mem_en),
      .mem_addr_o(mem_addr),
      .mem_data_i(mem_data)
   );

   dp_buffer i_dp_buffer (
      .clk    (clk),
      .we_i   (store_valid),
      .waddr_i(store_addr),
      .wdata_i(in_i),
      .re_i   (mem_en),
      .raddr_i(mem_addr),
      .rdata_o(mem_data)
   );

endmodule

//--- hdl/write_ctrl.sv
`timescale 1ns/100ps

module write_ctrl (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  run_i,
   input  vwrite_pkg::vw_cfg_t   cfg_i,
   input  logic                  store_done_i,
   input  logic                  rd_valid_i,
   input  logic                  bus_ready_i,
   input  logic                  bus_last_i,
   output logic                  done_o,
   output logic                  bus_valid_o,
   output vwrite_pkg::addr_t     store_start_o,
   output vwrite_pkg::addr_t     read_start_o,
   output logic                  read_run_o,
   output vwrite_pkg::bus_addr_t bus_addr_o,
   output vwrite_pkg::len_t      bus_len_o
);
   import vwrite_pkg::*;

   ctrl_state_t state_q;
   logic        write_done;
   logic        store_done;
   logic        pp_q;
   logic        beat_last;

   assign bus_valid_o = rd_valid_i && !write_done;
   assign beat_last   = bus_valid_o && bus_ready_i && bus_last_i;
   assign read_run_o  = run_i && cfg_i.enable_write;

   // top address bit picks the half, store and read sides are opposite
   assign read_start_o  = {cfg_i.ping_pong && !pp_q, {(ADDR_W-1){1'b0}}};
   assign store_start_o = {cfg_i.ping_pong && pp_q, cfg_i.store_start[ADDR_W-2:0]};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q    <= ST_IDLE;
         write_done <= 1'b1;
         store_done <= 1'b1;
         pp_q       <= 1'b0;
         done_o     <= 1'b1;
      end else if (run_i) begin
         state_q    <= ST_ACTIVE;
         write_done <= !cfg_i.enable_write;
         store_done <= 1'b0;
         pp_q       <= cfg_i.ping_pong && !pp_q;
         done_o     <= 1'b0;
      end else if (state_q == ST_ACTIVE) begin
         if (store_done_i) store_done <= 1'b1;
         if (beat_last) write_done <= 1'b1;
         if (write_done && store_done) begin
            state_q <= ST_IDLE;
            done_o  <= 1'b1;
         end
      end
   end

   // bus address and length held for the whole burst
   always_ff @(posedge clk) begin
      if (run_i) begin
         bus_addr_o <= cfg_i.ext_addr;
         bus_len_o  <= cfg_i.length;
      end
   end

endmodule

//--- hdl/dp_buffer.sv
`timescale 1ns/100ps

module dp_buffer (
   input  logic              clk,
   input  logic              we_i,
   input  vwrite_pkg::addr_t waddr_i,
   input  vwrite_pkg::data_t wdata_i,
   input  logic              re_i,
   input  vwrite_pkg::addr_t raddr_i,
   output vwrite_pkg::data_t rdata_o
);
   import vwrite_pkg::*;

   data_t mem_q [2**ADDR_W];

   // store side port
   always_ff @(posedge clk) begin
      if (we_i) begin
         mem_q[waddr_i] <= wdata_i;
      end
   end

   // read port, data valid the next cycle
   always_ff @(posedge clk) begin
      if (re_i) begin
         rdata_o <= mem_q[raddr_i];
      end
   end

endmodule

//--- hdl/mem_reader.sv
`timescale 1ns/100ps

module mem_reader #(
   parameter int FIFO_DEPTH = 2
) (
   input  logic              clk,
   input  logic              rst,
   input  logic              s_valid_i,
   input  vwrite_pkg::addr_t s_addr_i,
   output logic              s_ready_o,
   output logic              m_valid_o,
   input  logic              m_ready_i,
   output vwrite_pkg::data_t m_data_o,
   output logic              mem_en_o,
   output vwrite_pkg::addr_t mem_addr_o,
   input  vwrite_pkg::data_t mem_data_i
);
   import vwrite_pkg::*;

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
   localparam logic [CNT_W-1:0] DEPTH_C  = CNT_W'(FIFO_DEPTH);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

   data_t            queue_q [FIFO_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] q_cnt;
   logic [CNT_W-1:0] pend_cnt;    // reads in flight plus queued words
   logic             rd_inflight;
   logic             push;
   logic             pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == LAST_PTR) ? '0 : ptr + PTR_W'(1);
   endfunction

   assign pop        = m_valid_o && m_ready_i;
   assign push       = rd_inflight;
   assign m_valid_o  = (q_cnt != '0);
   assign m_data_o   = queue_q[rd_ptr];
   // a word leaving this cycle frees its slot at once
   assign s_ready_o  = (pend_cnt != DEPTH_C) || pop;
   assign mem_en_o   = s_valid_i && s_ready_o;
   assign mem_addr_o = s_addr_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_inflight <= 1'b0;
         pend_cnt    <= '0;
         q_cnt       <= '0;
         wr_ptr      <= '0;
         rd_ptr      <= '0;
      end else begin
         rd_inflight <= mem_en_o;
         case ({mem_en_o, pop})
            2'b10:   pend_cnt <= pend_cnt + CNT_W'(1);
            2'b01:   pend_cnt <= pend_cnt - CNT_W'(1);
            default: pend_cnt <= pend_cnt;
         endcase
         case ({push, pop})
            2'b10:   q_cnt <= q_cnt + CNT_W'(1);
            2'b01:   q_cnt <= q_cnt - CNT_W'(1);
            default: q_cnt <= q_cnt;
         endcase
         if (push) wr_ptr <= next_ptr(wr_ptr);
         if (pop) rd_ptr <= next_ptr(rd_ptr);
      end
   end

   // buffer data arrives one cycle after the read
   always_ff @(posedge clk) begin
      if (push) queue_q[wr_ptr] <= mem_data_i;
   end

endmodule

//--- hdl/addr_gen.sv
`timescale 1ns/100ps

module addr_gen (
   input  logic                clk,
   input  logic                rst,
   input  logic                run_i,
   input  vwrite_pkg::addr_t   start_i,
   input  vwrite_pkg::addr_t   incr_i,
   input  vwrite_pkg::period_t period_i,
   input  vwrite_pkg::delay_t  delay_i,
   input  logic                ready_i,
   output logic                valid_o,
   output vwrite_pkg::addr_t   addr_o,
   output logic                done_o
);
   import vwrite_pkg::*;

   logic    busy;
   logic    accept;
   delay_t  delay_cnt;
   period_t items_left;
   addr_t   addr_q;

   // addresses only come out once the delay has run down
   assign valid_o = busy && (delay_cnt == '0);
   assign accept  = valid_o && ready_i;
   assign addr_o  = addr_q;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy       <= 1'b0;
         done_o     <= 1'b1;
         delay_cnt  <= '0;
         items_left <= '0;
      end else if (run_i) begin
         // empty period finishes right away
         busy       <= (period_i != '0);
         done_o     <= (period_i == '0);
         delay_cnt  <= delay_i;
         items_left <= period_i;
      end else if (busy) begin
         if (delay_cnt != '0) begin
            delay_cnt <= delay_cnt - delay_t'(1);
         end else if (accept) begin
            items_left <= items_left - period_t'(1);
            if (items_left == period_t'(1)) begin
               busy   <= 1'b0;
               done_o <= 1'b1;
            end
         end
      end
   end

   // address steps only on an accepted handshake
   always_ff @(posedge clk) begin
      if (run_i) begin
         addr_q <= start_i;
      end else if (accept) begin
         addr_q <= addr_q + incr_i;
      end
   end

endmodule

//--- hdl/vwrite_pkg.sv
package vwrite_pkg;

   localparam int ADDR_W     = 8;
   localparam int DATA_W     = 32;
   localparam int PERIOD_W   = 8;
   localparam int DELAY_W    = 6;
   localparam int LEN_W      = 8;
   localparam int BUS_ADDR_W = 32;

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [PERIOD_W-1:0]   period_t;
   typedef logic [DELAY_W-1:0]    delay_t;
   typedef logic [LEN_W-1:0]      len_t;
   typedef logic [BUS_ADDR_W-1:0] bus_addr_t;

   typedef enum logic {
      ST_IDLE,
      ST_ACTIVE
   } ctrl_state_t;

   // run configuration, sampled on the run pulse
   typedef struct packed {
      bus_addr_t ext_addr;
      addr_t     store_start;
      addr_t     store_incr;
      period_t   store_period;
      delay_t    store_delay;
      addr_t     read_incr;
      period_t   read_period;
      len_t      length;
      logic      ping_pong;
      logic      enable_write;
   } vw_cfg_t;

endpackage
